// File: design/alu_pkg.sv
// ========================================
// ALU package
// Operand types, operation codes, request and
// response structs and the timing constants
// shared by the integer execution unit
// ========================================

package alu_pkg;

	// Operand width and the derived operand types
	localparam int value_w = 64;

	// Depth of the multiply pipeline
	localparam int mul_stages = 3;

	// Restoring divider iterations, one quotient bit each
	localparam int div_steps = 64;

	typedef logic [value_w-1:0] value_t;
	typedef logic [2*value_w-1:0] double_value_t;

	// ========================================
	// Operation codes
	// ========================================

	// Already decoded operation, the order fixes the encoding
	typedef enum logic [4:0]
	{
		ADD, SUB, AND, OR, XOR, ANDC, NAND, NOR,
		XNOR, ORC, SEQ, SNE, SLT, SLE, SLTU, SLEU,
		CMP, ASL, LSR, ROL, ROR, ASR, MUL, MULU,
		MULH, MULUH, DIV, DIVU, MOD, MODU, BLEND, MOV
	} alu_op_t;

	// Latency class, decides which completion the unit waits for
	typedef enum logic [1:0]
	{
		SINGLE,
		MULTIPLY,
		DIVIDE
	} op_class_t;

	// Everything outside the multiply and divide groups finishes in one cycle
	function automatic op_class_t op_class(input alu_op_t op);
		case (op)
		MUL, MULU, MULH, MULUH:
			return MULTIPLY;
		DIV, DIVU, MOD, MODU:
			return DIVIDE;
		default:
			return SINGLE;
		endcase
	endfunction

	// ========================================
	// Issue and result payloads
	// ========================================

	// Issue request, 5 + 3 * 64 = 197 bits
	typedef struct packed
	{
		alu_op_t op;
		value_t  a;
		value_t  b;
		value_t  c;
	} alu_req_t;

	// Result word plus the divide-by-zero flag, 65 bits
	typedef struct packed
	{
		value_t value;
		logic   dbz;
	} alu_resp_t;

endpackage

// File: design/alu_cmp.sv
// ========================================
// ALU comparator
// Builds the signed and unsigned compare
// flag vector returned by CMP
// ========================================

`timescale 1ns/1ps

module alu_cmp import alu_pkg::*;
(
	input  value_t a,
	input  value_t b,
	output value_t flags
);

	logic eq;
	logic lt;
	logic ltu;

	// Only three real comparisons are needed, the rest derive from them
	assign eq  = (a == b);
	assign lt  = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	// Bit order from the LSB: eq ne lt le gt ge ltu leu gtu geu
	// Upper bits stay zero so software can test single flags
	assign flags = {
		{(value_w - 10){1'b0}},
		~ltu,
		~(ltu | eq),
		ltu | eq,
		ltu,
		~lt,
		~(lt | eq),
		lt | eq,
		lt,
		~eq,
		eq
	};

endmodule

// File: design/alu_blend.sv
// ========================================
// ALU alpha blender
// Mixes two colour words byte by byte under
// an 8-bit alpha taken from the low byte
// ========================================

`timescale 1ns/1ps

module alu_blend import alu_pkg::*;
(
	input  value_t alpha,
	input  value_t c0,
	input  value_t c1,
	output value_t o
);

	logic [7:0] alpha8;
	logic [8:0] alpha_inv;

	// Only the low byte carries the weight
	assign alpha8 = alpha[7:0];

	// Weight of c1, one through 256 so alpha 0 passes c1 unchanged
	assign alpha_inv = 9'd256 - {1'b0, alpha8};

	// One identical lane per byte channel
	for (genvar i = 0; i < value_w / 8; i++)
	begin : g_lane
		logic [7:0] p0;
		logic [7:0] p1;
		logic [16:0] sum;

		assign p0 = c0[i*8 +: 8];
		assign p1 = c1[i*8 +: 8];

		// The weights add up to 256 so the sum never passes 255 * 256
		assign sum = p0 * alpha8 + p1 * alpha_inv;
		assign o[i*8 +: 8] = sum[15:8];

		// A weighted mean can not leave the range of its inputs
		always_comb
		begin
			assert (sum[15:8] <= ((p0 > p1) ? p0 : p1))
			else $error("blend lane %0d above both inputs", i);
		end
	end

endmodule

// File: design/alu_divider.sv
// ========================================
// ALU divider
// Restoring shift-subtract divider for signed
// and unsigned operands, one bit per clock,
// with divide-by-zero detection
// ========================================

`timescale 1ns/1ps

module alu_divider import alu_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   ld,
	input  logic   sgn,
	input  value_t a,
	input  value_t b,
	output value_t quotient,
	output value_t remainder,
	output logic   dbz,
	output logic   done
);

	// Control state
	logic busy;
	logic [$clog2(div_steps + 1) - 1:0] cnt;

	// Working registers, q holds the dividend and collects quotient bits
	value_t q;
	value_t r;
	value_t d;
	value_t a_hold;
	logic neg_q;
	logic neg_r;

	// One restoring step
	logic [value_w:0] r_shift;
	logic [value_w:0] trial;

	// Bring the next dividend bit into the partial remainder
	assign r_shift = {r, q[value_w-1]};

	// Since r < d the trial result is negative exactly when bit 64 is set
	assign trial = r_shift - {1'b0, d};

	// ========================================
	// Sequencer
	// ========================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			dbz  <= 1'b0;
			cnt  <= '0;
		end
		else if (ld)
		begin
			busy <= 1'b1;
			done <= 1'b0;
			dbz  <= (b == '0);
			cnt  <= ($clog2(div_steps + 1))'(div_steps);
		end
		else if (busy)
		begin
			cnt <= cnt - 1'b1;
			// Last quotient bit goes in on this edge
			if (cnt == ($clog2(div_steps + 1))'(1))
			begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// Datapath, operands are turned into magnitudes at load
	always_ff @(posedge clk)
	begin
		if (ld)
		begin
			q      <= (sgn && a[value_w-1]) ? -a : a;
			d      <= (sgn && b[value_w-1]) ? -b : b;
			r      <= '0;
			a_hold <= a;
			neg_q  <= sgn && (a[value_w-1] ^ b[value_w-1]);
			neg_r  <= sgn && a[value_w-1];
		end
		else if (busy)
		begin
			if (!trial[value_w])
			begin
				r <= trial[value_w-1:0];
				q <= {q[value_w-2:0], 1'b1};
			end
			else
			begin
				r <= r_shift[value_w-1:0];
				q <= {q[value_w-2:0], 1'b0};
			end
		end
	end

	// Sign fix-up, the remainder follows the dividend
	// A zero divisor overrides with all ones and the original dividend
	assign quotient  = dbz ? '1 : (neg_q ? -q : q);
	assign remainder = dbz ? a_hold : (neg_r ? -r : r);

	// The exec unit must hold off a new divide until the current one ends
	a_ld_idle: assert property (@(posedge clk) disable iff (rst) ld |-> !busy)
	else $error("divider loaded while busy");

endmodule

// File: design/alu_core.sv
// ========================================
// ALU core
// Arithmetic, logic, shift, multiply, divide
// and blend paths with the result multiplexer
// ========================================

`timescale 1ns/1ps

module alu_core import alu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    ld,
	input  alu_op_t op,
	input  value_t  a,
	input  value_t  b,
	input  value_t  c,
	output value_t  o,
	output logic    mul_done,
	output logic    div_done,
	output logic    div_dbz
);

	// Shift windows are three operand widths wide
	logic [3*value_w-1:0] shl_win;
	logic [3*value_w-1:0] shr_win;
	logic [3*value_w-1:0] asr_win;

	// The last entry of each multiply pipeline holds the finished product
	double_value_t prod_s [mul_stages];
	double_value_t prod_u [mul_stages];

	// One bit per multiply stage tracks the operation started by ld
	logic [mul_stages-1:0] mul_sr;

	// Sub-block results
	value_t cmp_flags;
	value_t blend_o;
	value_t div_q;
	value_t div_r;
	logic div_sgn;
	logic div_ld;

	// ========================================
	// Shifter
	// ========================================

	// a sits in the middle third and bits leaving it land in an outer third
	// For rotates the outer third is ORed back in
	assign shl_win = {{value_w{1'b0}}, a, {value_w{1'b0}}} << b[5:0];
	assign shr_win = {{value_w{1'b0}}, a, {value_w{1'b0}}} >> b[5:0];
	// Upper third carries the sign so it fills in from the left
	assign asr_win = {{value_w{a[value_w-1]}}, a, {value_w{1'b0}}} >> b[5:0];

	// ========================================
	// Multiplier
	// ========================================

	// A new operand pair enters the free-running pipeline every clock
	always_ff @(posedge clk)
	begin
		prod_s[0] <= $signed(a) * $signed(b);
		prod_u[0] <= a * b;
		for (int i = 1; i < mul_stages; i++)
		begin
			prod_s[i] <= prod_s[i-1];
			prod_u[i] <= prod_u[i-1];
		end
	end

	// ld restarts the tracker and its token reaches the top together with the product
	always_ff @(posedge clk)
	begin
		if (rst)
			mul_sr <= '0;
		else if (ld)
			mul_sr <= {{(mul_stages - 1){1'b0}}, 1'b1};
		else
			mul_sr <= {mul_sr[mul_stages-2:0], 1'b0};
	end

	assign mul_done = mul_sr[mul_stages-1];

	// ========================================
	// Sub-blocks
	// ========================================

	// DIV and MOD are the signed forms
	assign div_sgn = (op == DIV) || (op == MOD);

	// Only divide operations start the divider so it stays idle between them
	assign div_ld = ld && (op_class(op) == DIVIDE);

	alu_cmp u_cmp
	(
		.a     (a),
		.b     (b),
		.flags (cmp_flags)
	);

	alu_divider u_div
	(
		.clk       (clk),
		.rst       (rst),
		.ld        (div_ld),
		.sgn       (div_sgn),
		.a         (a),
		.b         (b),
		.quotient  (div_q),
		.remainder (div_r),
		.dbz       (div_dbz),
		.done      (div_done)
	);

	// The alpha comes from c while a and b are the two colours
	alu_blend u_blend
	(
		.alpha (c),
		.c0    (a),
		.c1    (b),
		.o     (blend_o)
	);

	// ========================================
	// Result multiplexer
	// ========================================

	always_comb
	begin
		case (op)
		ADD:   o = a + b;
		SUB:   o = a - b;
		AND:   o = a & b;
		OR:    o = a | b;
		XOR:   o = a ^ b;
		ANDC:  o = a & ~b;
		NAND:  o = ~(a & b);
		NOR:   o = ~(a | b);
		XNOR:  o = ~(a ^ b);
		ORC:   o = a | ~b;
		// Set operations give 0 or 1
		SEQ:   o = value_t'(a == b);
		SNE:   o = value_t'(a != b);
		SLT:   o = value_t'($signed(a) < $signed(b));
		SLE:   o = value_t'($signed(a) <= $signed(b));
		SLTU:  o = value_t'(a < b);
		SLEU:  o = value_t'(a <= b);
		CMP:   o = cmp_flags;
		ASL:   o = shl_win[2*value_w-1:value_w];
		LSR:   o = shr_win[2*value_w-1:value_w];
		ROL:   o = shl_win[2*value_w-1:value_w] | shl_win[3*value_w-1:2*value_w];
		ROR:   o = shr_win[2*value_w-1:value_w] | shr_win[value_w-1:0];
		ASR:   o = asr_win[2*value_w-1:value_w];
		MUL:   o = prod_s[mul_stages-1][value_w-1:0];
		MULU:  o = prod_u[mul_stages-1][value_w-1:0];
		MULH:  o = prod_s[mul_stages-1][2*value_w-1:value_w];
		MULUH: o = prod_u[mul_stages-1][2*value_w-1:value_w];
		DIV:   o = div_q;
		DIVU:  o = div_q;
		MOD:   o = div_r;
		MODU:  o = div_r;
		BLEND: o = blend_o;
		MOV:   o = a;
		default: o = '0;
		endcase
	end

endmodule

// File: design/alu_exec_unit.sv
// ========================================
// Integer execution unit
// Accepts one request on the issue handshake,
// runs it through the ALU core and returns a
// registered result with a valid pulse
// ========================================

`timescale 1ns/1ps

module alu_exec_unit import alu_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      issue_valid,
	input  alu_req_t  issue_req,
	output logic      issue_ready,
	output logic      result_valid,
	output alu_resp_t result
);

	// Control state
	logic pending;
	logic ld;
	op_class_t cls;

	// The latched request is held until the result is registered
	alu_req_t req;

	// Core outputs
	value_t core_o;
	logic mul_done;
	logic div_done;
	logic div_dbz;

	logic accept;
	logic complete;

	// Only one operation is in flight and ready comes back in the result cycle
	assign issue_ready = !pending;
	assign accept = issue_valid && issue_ready;

	// Single-cycle ops finish in the ld cycle
	// A stale div_done from the previous divide is still up while ld is high
	assign complete = pending && (
		(cls == SINGLE && ld) ||
		(cls == MULTIPLY && mul_done) ||
		(cls == DIVIDE && !ld && div_done));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pending      <= 1'b0;
			ld           <= 1'b0;
			result_valid <= 1'b0;
			cls          <= SINGLE;
		end
		else
		begin
			ld           <= accept;
			result_valid <= complete;
			if (accept)
			begin
				pending <= 1'b1;
				cls     <= op_class(issue_req.op);
			end
			else if (complete)
				pending <= 1'b0;
		end
	end

	// Payload registers
	always_ff @(posedge clk)
	begin
		if (accept)
			req <= issue_req;
		if (complete)
		begin
			result.value <= core_o;
			result.dbz   <= (cls == DIVIDE) ? div_dbz : 1'b0;
		end
	end

	alu_core u_core
	(
		.clk      (clk),
		.rst      (rst),
		.ld       (ld),
		.op       (req.op),
		.a        (req.a),
		.b        (req.b),
		.c        (req.c),
		.o        (core_o),
		.mul_done (mul_done),
		.div_done (div_done),
		.div_dbz  (div_dbz)
	);

	// Every result pulse answers an operation accepted earlier and reopens the issue port
	a_result_owned: assert property (@(posedge clk) disable iff (rst)
		result_valid |-> $past(pending) && issue_ready)
	else $error("result_valid without a pending operation or with issue_ready low");

endmodule

// File: tests/alu_tb.sv
// ========================================
// ALU execution unit testbench
// Replays the vector file through the issue
// port and checks values, flags and latency
// ========================================

`timescale 1ns/1ps

module alu_tb import alu_pkg::*;
();

	localparam int max_vec = 256;

	logic clk;
	logic rst;
	logic issue_valid;
	alu_req_t issue_req;
	logic issue_ready;
	logic result_valid;
	alu_resp_t result;

	// Vector table loaded from the input file
	alu_op_t vec_op [max_vec];
	value_t vec_a [max_vec];
	value_t vec_b [max_vec];
	value_t vec_c [max_vec];
	value_t vec_exp [max_vec];
	logic vec_dbz [max_vec];
	int n_vec = 0;

	// Accepted operations wait for their result in issue order
	int pend_idx [$];
	int pend_cyc [$];

	int n_done = 0;
	int cyc = 0;
	int limit = 100;
	int value_errs = 0;
	int proto_errs = 0;
	int timeout_errs = 0;
	logic [31:0] seed = 32'h60c;

	alu_exec_unit i_dut
	(
		.clk          (clk),
		.rst          (rst),
		.issue_valid  (issue_valid),
		.issue_req    (issue_req),
		.issue_ready  (issue_ready),
		.result_valid (result_valid),
		.result       (result)
	);

	always #5 clk = ~clk;

	// ========================================
	// Helpers
	// ========================================

	// Plain LCG whose upper bits are the better ones
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string name, input value_t expected,
		input value_t actual);
		if (actual !== expected)
		begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			value_errs++;
		end
	endtask

	task automatic finish_run();
		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errs, proto_errs, timeout_errs);
		if (value_errs + proto_errs + timeout_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// Lines starting with # are comments and the rest hold six hex fields
	task automatic load_vectors();
		int fd;
		int n;
		logic [8*256-1:0] line;
		logic [7:0] op_v;
		value_t a_v;
		value_t b_v;
		value_t c_v;
		value_t e_v;
		logic [7:0] d_v;
		fd = $fopen("tests/alu_input.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the vector file tests/alu_input.txt");
			proto_errs++;
			return;
		end
		while (!$feof(fd) && n_vec < max_vec)
		begin
			line = '0;
			n = $fgets(line, fd);
			if (n > 1 && line[8*n-1 -: 8] != "#")
			begin
				n = $sscanf(line, "%h %h %h %h %h %h",
					op_v, a_v, b_v, c_v, e_v, d_v);
				if (n == 6)
				begin
					vec_op[n_vec] = alu_op_t'(op_v[4:0]);
					vec_a[n_vec] = a_v;
					vec_b[n_vec] = b_v;
					vec_c[n_vec] = c_v;
					vec_exp[n_vec] = e_v;
					vec_dbz[n_vec] = d_v[0];
					n_vec++;
				end
			end
		end
		$fclose(fd);
		if (n_vec == 0)
		begin
			$display("no test vectors found in tests/alu_input.txt");
			proto_errs++;
		end
	endtask

	// Holds the request until the unit takes it since ready only moves on a rising edge
	task automatic send_vector(input int i);
		issue_valid = 1'b1;
		issue_req.op = vec_op[i];
		issue_req.a = vec_a[i];
		issue_req.b = vec_b[i];
		issue_req.c = vec_c[i];
		while (!issue_ready)
			@(negedge clk);
		@(negedge clk);
		issue_valid = 1'b0;
	endtask

	// ========================================
	// Monitor
	// ========================================

	always @(posedge clk)
	begin
		int idx;
		int lat;
		string name;
		cyc = cyc + 1;
		if (!rst)
		begin
			if (result_valid && pend_idx.size() == 0)
			begin
				$display("result_valid at cycle %0d with no operation outstanding", cyc);
				proto_errs++;
			end
			else if (result_valid)
			begin
				idx = pend_idx.pop_front();
				lat = cyc - pend_cyc.pop_front();
				name = $sformatf("vec%0d %s", idx, vec_op[idx].name());
				check_value(name, vec_exp[idx], result.value);
				check_value({name, " dbz"}, value_t'(vec_dbz[idx]), value_t'(result.dbz));
				// MUL through MULUH take five edges and DIV through MODU at least div_steps
				if (vec_op[idx] >= MUL && vec_op[idx] <= MULUH)
				begin
					if (lat != 5)
					begin
						$display("%s multiply result came %0d edges after acceptance",
							name, lat);
						proto_errs++;
					end
				end
				else if (vec_op[idx] >= DIV && vec_op[idx] <= MODU)
				begin
					if (lat < div_steps)
					begin
						$display("%s divide finished after only %0d edges",
							name, lat);
						proto_errs++;
					end
				end
				else if (lat != 2)
				begin
					$display("%s single-cycle result came %0d edges after acceptance",
						name, lat);
					proto_errs++;
				end
				n_done++;
			end
			if (result_valid && !issue_ready)
			begin
				$display("issue_ready low at cycle %0d in the result cycle", cyc);
				proto_errs++;
			end
			if (pend_idx.size() > 0 && issue_ready && !result_valid)
			begin
				$display("issue_ready high at cycle %0d while an operation is outstanding",
					cyc);
				proto_errs++;
			end
			if (issue_valid && issue_ready)
			begin
				pend_idx.push_back(n_done + pend_idx.size());
				pend_cyc.push_back(cyc);
			end
		end
		if (cyc >= limit)
		begin
			$display("timeout after %0d cycles with %0d of %0d results",
				cyc, n_done, n_vec);
			timeout_errs++;
			finish_run();
		end
	end

	// ========================================
	// Stimulus
	// ========================================

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		issue_valid = 1'b0;
		issue_req = '0;
		load_vectors();
		limit = n_vec * (div_steps + 10) + 100;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < n_vec; i++)
		begin
			send_vector(i);
			seed = lcg_next(seed);
			repeat (seed[17:16]) @(negedge clk);
		end
		while (n_done < n_vec)
			@(posedge clk);
		repeat (2) @(posedge clk);
		finish_run();
	end

endmodule

// File: sim.f
design/alu_pkg.sv
design/alu_cmp.sv
design/alu_blend.sv
design/alu_divider.sv
design/alu_core.sv
design/alu_exec_unit.sv
tests/alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the ALU execution unit testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module alu_tb \
	--Mdir obj_dir -o alu_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/alu_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0

// File: tests/alu_input.txt
# op a b c expected dbz, all hex, op is the alu_op_t encoding
# Arithmetic and logic, ADD SUB AND OR XOR ANDC NAND NOR XNOR ORC MOV
00 ffffffffffffffff 1 0 0 0
01 0 1 0 ffffffffffffffff 0
02 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 f000f000f000f000 0
03 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 fff0fff0fff0fff0 0
04 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 0ff00ff00ff00ff0 0
05 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 00f000f000f000f0 0
06 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 0fff0fff0fff0fff 0
07 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 000f000f000f000f 0
08 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 f00ff00ff00ff00f 0
09 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0 f0fff0fff0fff0ff 0
1f 123456789abcdef0 0 0 123456789abcdef0 0
# Set operations SEQ SNE SLT SLE SLTU SLEU
0a 5 5 0 1 0
0b 5 5 0 0 0
0c ffffffffffffffff 1 0 1 0
0d 1 1 0 1 0
0e ffffffffffffffff 1 0 0 0
0f ffffffffffffffff 1 0 0 0
# CMP flags for equal, signed-less and unsigned-less pairs
10 7 7 0 2a9 0
10 ffffffffffffffff 1 0 30e 0
10 1 ffffffffffffffff 0 f2 0
# ASL LSR ROL ROR ASR by 0, 1, 32 and 63
11 8000000000000001 0 0 8000000000000001 0
11 8000000000000001 1 0 2 0
11 8000000000000001 20 0 100000000 0
11 8000000000000001 3f 0 8000000000000000 0
12 8000000000000001 0 0 8000000000000001 0
12 8000000000000001 1 0 4000000000000000 0
12 8000000000000001 20 0 80000000 0
12 8000000000000001 3f 0 1 0
13 8000000000000001 0 0 8000000000000001 0
13 8000000000000001 1 0 3 0
13 8000000000000001 20 0 180000000 0
13 8000000000000001 3f 0 c000000000000000 0
14 8000000000000001 0 0 8000000000000001 0
14 8000000000000001 1 0 c000000000000000 0
14 8000000000000001 20 0 180000000 0
14 8000000000000001 3f 0 3 0
15 8000000000000001 0 0 8000000000000001 0
15 8000000000000001 1 0 c000000000000000 0
15 8000000000000001 20 0 ffffffff80000000 0
15 8000000000000001 3f 0 ffffffffffffffff 0
# MUL MULU MULH MULUH
16 ffffffffffffffff 3 0 fffffffffffffffd 0
17 ffffffffffffffff 3 0 fffffffffffffffd 0
18 ffffffffffffffff 3 0 ffffffffffffffff 0
19 ffffffffffffffff 3 0 2 0
16 100000000 100000000 0 0 0
18 100000000 100000000 0 1 0
18 8000000000000000 2 0 ffffffffffffffff 0
19 8000000000000000 2 0 1 0
# DIV DIVU MOD MODU with mixed signs, then a zero divisor
1a fffffffffffffff9 2 0 fffffffffffffffd 0
1c fffffffffffffff9 2 0 ffffffffffffffff 0
1a 7 fffffffffffffffe 0 fffffffffffffffd 0
1c 7 fffffffffffffffe 0 1 0
1a fffffffffffffff9 fffffffffffffffe 0 3 0
1c fffffffffffffff9 fffffffffffffffe 0 ffffffffffffffff 0
1b ffffffffffffffff 2 0 7fffffffffffffff 0
1d ffffffffffffffff 2 0 1 0
1b 64 7 0 e 0
1d 64 7 0 2 0
1a 1234 0 0 ffffffffffffffff 1
1c 1234 0 0 1234 1
1b ffffffffffffffff 0 0 ffffffffffffffff 1
1d fffffffffffffff9 0 0 fffffffffffffff9 1
# BLEND with alpha 0, 255 and 128 in the low byte of c
1e ffffffffffffffff 0011223344556677 0 0011223344556677 0
1e ffffffffffffffff 0 ff fefefefefefefefe 0
1e ff80402010080402 0101010101010101 180 8040201008040201 0
